//--- common/qed_mem_pkg.sv
/* Shared sizes, AXI4-Lite address map, response codes and FSM state
   encodings for the power-gated queue-entry register file */

package qed_mem_pkg;

    // ------------------------------
    // Register file geometry
    // ------------------------------

    localparam int RF_DEPTH  = 4;
    localparam int RF_ADDR_W = 2;
    localparam int RF_DATA_W = 8;

    // Enable chain length of the macro, in clock cycles
    localparam int PG_CHAIN_DELAY = 4;

    // ------------------------------
    // AXI4-Lite front end
    // ------------------------------

    localparam int AXI_ADDR_W = 8;
    localparam int AXI_DATA_W = 32;

    // Entries sit one per word starting at ENTRY_BASE
    localparam logic [AXI_ADDR_W-1:0] ENTRY_BASE    = 8'h00;
    // Bit 0 requests power, 1 means on
    localparam logic [AXI_ADDR_W-1:0] PWR_CTRL_ADDR = 8'h10;
    // Bit 0 powered, bit 1 isolated
    localparam logic [AXI_ADDR_W-1:0] PWR_STAT_ADDR = 8'h14;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axi_resp_e;

    // Power gate sequencing, isolation wraps the enable chain on both edges
    typedef enum logic [2:0] {
        PG_ON,
        PG_ISOLATE,
        PG_OFF_WAIT,
        PG_OFF,
        PG_ON_WAIT,
        PG_RELEASE
    } pg_state_e;

    typedef enum logic [1:0] {
        IDLE,
        WRITE_RESP,
        READ_RF,
        READ_RESP
    } axil_state_e;

endpackage

//--- common/rf_access_if.sv
/* Write and read port bundle between the register front end and the
   register file wrapper */

`timescale 1ns/1ps

interface rf_access_if;

    // Write port, the write lands on the edge where we is high
    logic                             we;
    logic [qed_mem_pkg::RF_ADDR_W-1:0] waddr;
    logic [qed_mem_pkg::RF_DATA_W-1:0] wdata;

    // Read port, rdata follows one edge after re
    logic                             re;
    logic [qed_mem_pkg::RF_ADDR_W-1:0] raddr;
    logic [qed_mem_pkg::RF_DATA_W-1:0] rdata;

    modport requester (
        output we, waddr, wdata,
        output re, raddr,
        input  rdata
    );

    modport memory (
        input  we, waddr, wdata,
        input  re, raddr,
        output rdata
    );

endinterface

//--- source/mem_reset_sync_scan.sv
/* Two flop reset synchronizer with scan reset bypass */

`timescale 1ns/1ps

module mem_reset_sync_scan (
    input  logic clk,
    input  logic rst_n,
    input  logic fscan_rstbypen,
    input  logic fscan_byprst_b,
    output logic rst_n_sync
);

    logic [1:0] sync_q;

    // Assertion takes effect at the next edge, release ripples through
    // both stages so the output deasserts two edges after rst_n rises
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sync_q <= 2'b00;
        end else begin
            sync_q <= {sync_q[0], 1'b1};
        end
    end

    // Scan mode hands reset control straight to the tester
    assign rst_n_sync = fscan_rstbypen ? fscan_byprst_b : sync_q[1];

endmodule

//--- rf_pg/rf_array_4x8.sv
/* Behavioral two port 4x8 register file with a power enable chain,
   output isolation and a registered read */

`timescale 1ns/1ps

module rf_array_4x8 (
    input  logic                             wclk,
    input  logic                             we,
    input  logic [qed_mem_pkg::RF_ADDR_W-1:0] waddr,
    input  logic [qed_mem_pkg::RF_DATA_W-1:0] wdata,
    input  logic                             rclk,
    input  logic                             re,
    input  logic [qed_mem_pkg::RF_ADDR_W-1:0] raddr,
    output logic [qed_mem_pkg::RF_DATA_W-1:0] rdata,
    input  logic                             ip_reset_b,
    input  logic                             isol_en,
    input  logic                             pwr_enable_b_in,
    output logic                             pwr_enable_b_out
);

    logic [qed_mem_pkg::RF_DATA_W-1:0]      mem [qed_mem_pkg::RF_DEPTH];
    logic [qed_mem_pkg::RF_DEPTH-1:0]       valid;
    logic [qed_mem_pkg::PG_CHAIN_DELAY-1:0] chain_q;
    logic [qed_mem_pkg::RF_DATA_W-1:0]      rd_q;
    logic                                   pwr_off;

    // ------------------------------
    // Power enable chain
    // ------------------------------

    // Each stage models one power switch segment turning on or off
    always_ff @(posedge wclk) begin
        if (!ip_reset_b) begin
            chain_q <= '0;
        end else begin
            chain_q <= {chain_q[qed_mem_pkg::PG_CHAIN_DELAY-2:0], pwr_enable_b_in};
        end
    end

    assign pwr_enable_b_out = chain_q[qed_mem_pkg::PG_CHAIN_DELAY-1];

    // The array counts as unpowered as soon as any segment is switched off
    assign pwr_off = pwr_enable_b_in | pwr_enable_b_out;

    // ------------------------------
    // Storage
    // ------------------------------

    // Losing power drops every entry, only a fresh write brings one back
    always_ff @(posedge wclk) begin
        if (pwr_off) begin
            valid <= '0;
        end else if (we) begin
            mem[waddr]   <= wdata;
            valid[waddr] <= 1'b1;
        end
    end

    // Entries lost to a power cycle read back as unknown
    always_ff @(posedge rclk) begin
        if (!ip_reset_b) begin
            rd_q <= '0;
        end else if (re) begin
            rd_q <= (valid[raddr] && !pwr_off) ? mem[raddr] : 'x;
        end
    end

    // Clamp the output so a collapsing array never drives the fabric
    assign rdata = isol_en ? '0 : rd_q;

endmodule

//--- rf_pg/qed_mem_rf_pg_4x8.sv
/* Power gated 4x8 queue-entry memory wrapper with IP reset
   synchronizer and register file array */

`timescale 1ns/1ps

module qed_mem_rf_pg_4x8 (
    input  logic           clk,
    rf_access_if.memory    rf,
    input  logic           isol_en,
    input  logic           pwr_enable_b,
    output logic           pwr_enable_b_out,
    input  logic           ip_reset_b,
    input  logic           fscan_rstbypen,
    input  logic           fscan_byprst_b
);

    logic ip_reset_b_sync;

    // ------------------------------
    // IP reset, synchronized to the read clock
    // ------------------------------

    mem_reset_sync_scan u_ip_reset_sync (
        .clk            (clk),
        .rst_n          (ip_reset_b),
        .fscan_rstbypen (fscan_rstbypen),
        .fscan_byprst_b (fscan_byprst_b),
        .rst_n_sync     (ip_reset_b_sync)
    );

    // ------------------------------
    // Register file array
    // ------------------------------

    // Write and read clocks share the single design clock
    rf_array_4x8 u_rf (
        .wclk             (clk),
        .we               (rf.we),
        .waddr            (rf.waddr),
        .wdata            (rf.wdata),
        .rclk             (clk),
        .re               (rf.re),
        .raddr            (rf.raddr),
        .rdata            (rf.rdata),
        .ip_reset_b       (ip_reset_b_sync),
        .isol_en          (isol_en),
        .pwr_enable_b_in  (pwr_enable_b),
        .pwr_enable_b_out (pwr_enable_b_out)
    );

endmodule

//--- source/pwr_gate_ctrl.sv
/* Power gate controller sequencing isolation around the memory
   power enable chain */

`timescale 1ns/1ps

module pwr_gate_ctrl (
    input  logic clk,
    input  logic rst_n,
    input  logic pwr_req,
    input  logic pwr_enable_b_out,
    output logic isol_en,
    output logic pwr_enable_b,
    output logic powered,
    output logic isolated
);

    qed_mem_pkg::pg_state_e state;

    // Wait states ignore pwr_req, a new request is picked up
    // only once the sequence in flight has settled
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= qed_mem_pkg::PG_ON;
        end else begin
            case (state)
                qed_mem_pkg::PG_ON: begin
                    if (!pwr_req) state <= qed_mem_pkg::PG_ISOLATE;
                end
                // Clamp outputs for one cycle before the chain switches off
                qed_mem_pkg::PG_ISOLATE: state <= qed_mem_pkg::PG_OFF_WAIT;
                qed_mem_pkg::PG_OFF_WAIT: begin
                    if (pwr_enable_b_out) state <= qed_mem_pkg::PG_OFF;
                end
                qed_mem_pkg::PG_OFF: begin
                    if (pwr_req) state <= qed_mem_pkg::PG_ON_WAIT;
                end
                // Isolation stays until the last segment reports power
                qed_mem_pkg::PG_ON_WAIT: begin
                    if (!pwr_enable_b_out) state <= qed_mem_pkg::PG_RELEASE;
                end
                qed_mem_pkg::PG_RELEASE: state <= qed_mem_pkg::PG_ON;
                default: state <= qed_mem_pkg::PG_ON;
            endcase
        end
    end

    // Isolation is low only in the fully powered state
    assign isol_en = (state != qed_mem_pkg::PG_ON);

    // The enable chain is driven off from the off wait until the on request
    assign pwr_enable_b = (state == qed_mem_pkg::PG_OFF_WAIT) ||
                          (state == qed_mem_pkg::PG_OFF);

    // Power is reported lost only once the chain has acknowledged it
    assign powered = (state == qed_mem_pkg::PG_ON)      ||
                     (state == qed_mem_pkg::PG_ISOLATE) ||
                     (state == qed_mem_pkg::PG_OFF_WAIT);

    assign isolated = isol_en;

endmodule

//--- source/axil_mem_regs.sv
/* AXI4-Lite slave mapping register file entries, power request
   and power status */

`timescale 1ns/1ps

module axil_mem_regs (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic [qed_mem_pkg::AXI_ADDR_W-1:0]   awaddr,
    input  logic                                awvalid,
    output logic                                awready,
    input  logic [qed_mem_pkg::AXI_DATA_W-1:0]   wdata,
    input  logic [qed_mem_pkg::AXI_DATA_W/8-1:0] wstrb,
    input  logic                                wvalid,
    output logic                                wready,
    output logic [1:0]                          bresp,
    output logic                                bvalid,
    input  logic                                bready,
    input  logic [qed_mem_pkg::AXI_ADDR_W-1:0]   araddr,
    input  logic                                arvalid,
    output logic                                arready,
    output logic [qed_mem_pkg::AXI_DATA_W-1:0]   rdata,
    output logic                                rvalid,
    output logic [1:0]                          rresp,
    input  logic                                rready,
    rf_access_if.requester                      rf,
    output logic                                pwr_req,
    input  logic                                powered,
    input  logic                                isolated
);

    qed_mem_pkg::axil_state_e state;
    qed_mem_pkg::axi_resp_e   resp_q;
    logic [qed_mem_pkg::AXI_DATA_W-1:0] rdata_q;
    logic rd_from_rf;
    logic mem_ok;
    logic ar_hs;

    // Word aligned address inside the entry window
    function automatic logic is_entry(input logic [qed_mem_pkg::AXI_ADDR_W-1:0] a);
        return (a[qed_mem_pkg::AXI_ADDR_W-1:qed_mem_pkg::RF_ADDR_W+2] ==
                qed_mem_pkg::ENTRY_BASE[qed_mem_pkg::AXI_ADDR_W-1:qed_mem_pkg::RF_ADDR_W+2])
               && (a[1:0] == 2'b00);
    endfunction

    // ------------------------------
    // Handshakes
    // ------------------------------

    // A write is taken only with address and data together, and wins over a read
    assign awready = (state == qed_mem_pkg::IDLE) && awvalid && wvalid;
    assign wready  = awready;
    assign arready = (state == qed_mem_pkg::IDLE) && !(awvalid && wvalid);
    assign ar_hs   = arready && arvalid;

    // Entries are reachable only when fully powered and not clamped
    assign mem_ok = powered && !isolated;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= qed_mem_pkg::IDLE;
            pwr_req <= 1'b1;
            rf.we   <= 1'b0;
            rf.re   <= 1'b0;
        end else begin
            // Port strobes last a single cycle
            rf.we <= 1'b0;
            rf.re <= 1'b0;
            case (state)
                qed_mem_pkg::IDLE: begin
                    if (awready) begin
                        state    <= qed_mem_pkg::WRITE_RESP;
                        resp_q   <= qed_mem_pkg::OKAY;
                        rf.waddr <= awaddr[qed_mem_pkg::RF_ADDR_W+1:2];
                        rf.wdata <= wdata[qed_mem_pkg::RF_DATA_W-1:0];
                        if (is_entry(awaddr)) begin
                            if (!mem_ok) begin
                                resp_q <= qed_mem_pkg::SLVERR;
                            end else if (wstrb[0]) begin
                                rf.we <= 1'b1;
                            end
                        end else if (awaddr == qed_mem_pkg::PWR_CTRL_ADDR) begin
                            if (wstrb[0]) pwr_req <= wdata[0];
                        end else if (awaddr != qed_mem_pkg::PWR_STAT_ADDR) begin
                            resp_q <= qed_mem_pkg::SLVERR;
                        end
                    end else if (ar_hs) begin
                        state      <= qed_mem_pkg::READ_RESP;
                        resp_q     <= qed_mem_pkg::OKAY;
                        rdata_q    <= '0;
                        rd_from_rf <= 1'b0;
                        rf.raddr   <= araddr[qed_mem_pkg::RF_ADDR_W+1:2];
                        if (is_entry(araddr)) begin
                            // Entry reads spend one cycle in the array read register
                            if (mem_ok) begin
                                state      <= qed_mem_pkg::READ_RF;
                                rf.re      <= 1'b1;
                                rd_from_rf <= 1'b1;
                            end else begin
                                resp_q <= qed_mem_pkg::SLVERR;
                            end
                        end else if (araddr == qed_mem_pkg::PWR_CTRL_ADDR) begin
                            rdata_q[0] <= pwr_req;
                        end else if (araddr == qed_mem_pkg::PWR_STAT_ADDR) begin
                            rdata_q[1:0] <= {isolated, powered};
                        end else begin
                            resp_q <= qed_mem_pkg::SLVERR;
                        end
                    end
                end
                qed_mem_pkg::WRITE_RESP: begin
                    if (bready) state <= qed_mem_pkg::IDLE;
                end
                qed_mem_pkg::READ_RF: state <= qed_mem_pkg::READ_RESP;
                qed_mem_pkg::READ_RESP: begin
                    if (rready) state <= qed_mem_pkg::IDLE;
                end
                default: state <= qed_mem_pkg::IDLE;
            endcase
        end
    end

    // ------------------------------
    // Response channels
    // ------------------------------

    assign bvalid = (state == qed_mem_pkg::WRITE_RESP);
    assign bresp  = resp_q;
    assign rvalid = (state == qed_mem_pkg::READ_RESP);
    assign rresp  = resp_q;

    // The array read register holds its value while re stays low
    assign rdata = rd_from_rf ?
                   {{(qed_mem_pkg::AXI_DATA_W-qed_mem_pkg::RF_DATA_W){1'b0}}, rf.rdata} :
                   rdata_q;

endmodule

//--- source/qed_mem_top.sv
/* Top level joining the AXI4-Lite front end, power gate controller
   and power gated register file */

`timescale 1ns/1ps

module qed_mem_top (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                ip_reset_b,
    input  logic                                fscan_rstbypen,
    input  logic                                fscan_byprst_b,
    input  logic [qed_mem_pkg::AXI_ADDR_W-1:0]   awaddr,
    input  logic                                awvalid,
    output logic                                awready,
    input  logic [qed_mem_pkg::AXI_DATA_W-1:0]   wdata,
    input  logic [qed_mem_pkg::AXI_DATA_W/8-1:0] wstrb,
    input  logic                                wvalid,
    output logic                                wready,
    output logic [1:0]                          bresp,
    output logic                                bvalid,
    input  logic                                bready,
    input  logic [qed_mem_pkg::AXI_ADDR_W-1:0]   araddr,
    input  logic                                arvalid,
    output logic                                arready,
    output logic [qed_mem_pkg::AXI_DATA_W-1:0]   rdata,
    output logic                                rvalid,
    output logic [1:0]                          rresp,
    input  logic                                rready
);

    logic pwr_req;
    logic isol_en;
    logic pwr_enable_b;
    logic pwr_enable_b_out;
    logic powered;
    logic isolated;

    rf_access_if rf_bus ();

    // Host access and power request register
    axil_mem_regs u_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .awaddr   (awaddr),
        .awvalid  (awvalid),
        .awready  (awready),
        .wdata    (wdata),
        .wstrb    (wstrb),
        .wvalid   (wvalid),
        .wready   (wready),
        .bresp    (bresp),
        .bvalid   (bvalid),
        .bready   (bready),
        .araddr   (araddr),
        .arvalid  (arvalid),
        .arready  (arready),
        .rdata    (rdata),
        .rvalid   (rvalid),
        .rresp    (rresp),
        .rready   (rready),
        .rf       (rf_bus.requester),
        .pwr_req  (pwr_req),
        .powered  (powered),
        .isolated (isolated)
    );

    pwr_gate_ctrl u_pg_ctrl (
        .clk              (clk),
        .rst_n            (rst_n),
        .pwr_req          (pwr_req),
        .pwr_enable_b_out (pwr_enable_b_out),
        .isol_en          (isol_en),
        .pwr_enable_b     (pwr_enable_b),
        .powered          (powered),
        .isolated         (isolated)
    );

    // Memory keeps its own IP reset apart from the fabric reset
    qed_mem_rf_pg_4x8 u_mem (
        .clk              (clk),
        .rf               (rf_bus.memory),
        .isol_en          (isol_en),
        .pwr_enable_b     (pwr_enable_b),
        .pwr_enable_b_out (pwr_enable_b_out),
        .ip_reset_b       (ip_reset_b),
        .fscan_rstbypen   (fscan_rstbypen),
        .fscan_byprst_b   (fscan_byprst_b)
    );

endmodule

//--- dv/qed_mem_checker.sv
/* Response monitor for the queue-entry memory, compares B and R channels
   against the testbench model and counts mismatches */

`timescale 1ns/1ps

module qed_mem_checker (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [qed_mem_pkg::AXI_ADDR_W-1:0] araddr,
    input  logic                              arvalid,
    input  logic                              arready,
    input  logic [1:0]                        bresp,
    input  logic                              bvalid,
    input  logic                              bready,
    input  logic [qed_mem_pkg::AXI_DATA_W-1:0] rdata,
    input  logic [1:0]                        rresp,
    input  logic                              rvalid,
    input  logic                              rready,
    input  logic [1:0]                        exp_bresp,
    input  logic [1:0]                        exp_rresp,
    input  logic [qed_mem_pkg::AXI_DATA_W-1:0] exp_rdata,
    input  logic                              chk_rdata,
    output int                                errors,
    output int                                checked
);

    logic                              b_held;
    logic                              r_held;
    logic                              reg_rd;
    logic [1:0]                        bresp_q;
    logic [1:0]                        rresp_q;
    logic [qed_mem_pkg::AXI_DATA_W-1:0] rdata_q;

    task automatic flag_error(input string msg);
        $display("FAILED at %0t ns: %s", $time, msg);
        errors++;
    endtask

    // Sampling at the falling edge sees settled outputs and the inputs
    // that the next rising edge will act on
    always @(negedge clk) begin
        if (!rst_n) begin
            errors  = 0;
            checked = 0;
            b_held  <= 1'b0;
            r_held  <= 1'b0;
            reg_rd  <= 1'b0;
        end else begin
            // ------------------------------
            // Back-pressure holds the response unchanged
            // ------------------------------
            if (b_held && (!bvalid || bresp !== bresp_q))
                flag_error("B response dropped or changed before BREADY");
            if (r_held && (!rvalid || rresp !== rresp_q || rdata !== rdata_q))
                flag_error("R response dropped or changed before RREADY");
            // Register reads skip the array, so RVALID follows acceptance directly
            if (reg_rd && !rvalid)
                flag_error("RVALID not one cycle after AR acceptance on a register read");

            // Compare at the handshake
            if (bvalid && bready) begin
                checked++;
                if (bresp !== exp_bresp)
                    flag_error($sformatf("BRESP %0d, expected %0d", bresp, exp_bresp));
            end
            if (rvalid && rready) begin
                checked++;
                if (rresp !== exp_rresp)
                    flag_error($sformatf("RRESP %0d, expected %0d", rresp, exp_rresp));
                if (chk_rdata && rdata !== exp_rdata)
                    flag_error($sformatf("RDATA %h, expected %h", rdata, exp_rdata));
            end

            b_held  <= bvalid && !bready;
            r_held  <= rvalid && !rready;
            bresp_q <= bresp;
            rresp_q <= rresp;
            rdata_q <= rdata;
            reg_rd  <= arvalid && arready && (araddr == qed_mem_pkg::PWR_CTRL_ADDR ||
                                             araddr == qed_mem_pkg::PWR_STAT_ADDR);
        end
    end

endmodule

//--- dv/tb_qed_mem_top.sv
/* Testbench for the power-gated queue-entry memory with AXI4-Lite
   driver tasks, a reference model and seeded random stimulus */

`timescale 1ns/1ps

module tb_qed_mem_top;

    localparam int TIMEOUT    = 40;
    localparam int POLL_LIMIT = 20;

    logic        clk;
    logic        rst_n;
    logic        ip_reset_b;
    logic        fscan_rstbypen;
    logic        fscan_byprst_b;
    logic [7:0]  awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [7:0]  araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic        rvalid;
    logic [1:0]  rresp;
    logic        rready;

    // Expectations handed to the checker
    logic [1:0]  exp_bresp;
    logic [1:0]  exp_rresp;
    logic [31:0] exp_rdata;
    logic        chk_rdata;
    int          errors;
    int          checked;
    int          timeouts;

    // Reference model of the entries and the power state
    logic [7:0]  model_mem [qed_mem_pkg::RF_DEPTH];
    logic [3:0]  model_valid;
    logic        model_on;
    logic [31:0] last_rdata;
    logic [31:0] rnd;
    integer      seed;
    int          op;

    qed_mem_top u_dut (.*);

    qed_mem_checker u_checker (.*);

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // ------------------------------
    // AXI4-Lite driver tasks
    // ------------------------------

    task automatic write_word(input logic [7:0] addr, input logic [31:0] data,
                              input logic [3:0] strb, input logic [1:0] resp);
        int n;
        exp_bresp = resp;
        awaddr    = addr;
        wdata     = data;
        wstrb     = strb;
        awvalid   = 1'b1;
        wvalid    = 1'b1;
        n = 0;
        @(negedge clk);
        // Address and data are taken together in one handshake
        while (!(awready && wready) && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!(awready && wready)) begin
            $display("Timeout at %0t ns: AWREADY and WREADY never rose together", $time);
            timeouts++;
        end
        @(posedge clk);
        #1;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        // Hold BREADY back for 0 to 3 cycles
        rnd = $random(seed);
        repeat (rnd % 4) begin
            @(posedge clk);
            #1;
        end
        bready = 1'b1;
        n = 0;
        @(negedge clk);
        while (!bvalid && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!bvalid) begin
            $display("Timeout at %0t ns: no BVALID after a write", $time);
            timeouts++;
        end
        @(posedge clk);
        #1;
        bready = 1'b0;
    endtask

    task automatic read_word(input logic [7:0] addr, input logic [1:0] resp,
                             input logic [31:0] data, input logic chk);
        int n;
        exp_rresp = resp;
        exp_rdata = data;
        chk_rdata = chk;
        araddr    = addr;
        arvalid   = 1'b1;
        n = 0;
        @(negedge clk);
        while (!arready && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!arready) begin
            $display("Timeout at %0t ns: ARREADY never rose", $time);
            timeouts++;
        end
        @(posedge clk);
        #1;
        arvalid = 1'b0;
        rnd = $random(seed);
        repeat (rnd % 4) begin
            @(posedge clk);
            #1;
        end
        rready = 1'b1;
        n = 0;
        @(negedge clk);
        while (!rvalid && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!rvalid) begin
            $display("Timeout at %0t ns: no RVALID after a read", $time);
            timeouts++;
        end
        last_rdata = rdata;
        @(posedge clk);
        #1;
        rready = 1'b0;
    endtask

    // ------------------------------
    // Model-driven operations
    // ------------------------------

    // Entry access without power is refused and changes nothing
    task automatic store_entry(input logic [1:0] idx, input logic [7:0] data,
                               input logic [3:0] strb);
        write_word({4'h0, idx, 2'b00}, {24'h0, data}, strb,
                   model_on ? qed_mem_pkg::OKAY : qed_mem_pkg::SLVERR);
        if (model_on && strb[0]) begin
            model_mem[idx]   = data;
            model_valid[idx] = 1'b1;
        end
    endtask

    // Entries lost in a power cycle have no known value to compare
    task automatic load_entry(input logic [1:0] idx);
        if (!model_on)
            read_word({4'h0, idx, 2'b00}, qed_mem_pkg::SLVERR, 32'h0, 1'b1);
        else
            read_word({4'h0, idx, 2'b00}, qed_mem_pkg::OKAY, {24'h0, model_mem[idx]},
                      model_valid[idx]);
    endtask

    task automatic set_power(input logic on);
        logic [1:0] want;
        int n;
        // Status bit 1 is isolated, bit 0 is powered
        want = on ? 2'b01 : 2'b10;
        write_word(qed_mem_pkg::PWR_CTRL_ADDR, {31'h0, on}, 4'hF, qed_mem_pkg::OKAY);
        n = 0;
        read_word(qed_mem_pkg::PWR_STAT_ADDR, qed_mem_pkg::OKAY, 32'h0, 1'b0);
        while (last_rdata[1:0] != want && n < POLL_LIMIT) begin
            read_word(qed_mem_pkg::PWR_STAT_ADDR, qed_mem_pkg::OKAY, 32'h0, 1'b0);
            n++;
        end
        if (last_rdata[1:0] != want) begin
            $display("Timeout at %0t ns: power status never settled", $time);
            timeouts++;
        end
        read_word(qed_mem_pkg::PWR_STAT_ADDR, qed_mem_pkg::OKAY, {30'h0, want}, 1'b1);
        read_word(qed_mem_pkg::PWR_CTRL_ADDR, qed_mem_pkg::OKAY, {31'h0, on}, 1'b1);
        model_on    = on;
        model_valid = '0;
    endtask

    initial begin
        seed = 44;
        rst_n = 1'b0;
        ip_reset_b = 1'b0;
        fscan_rstbypen = 1'b0;
        fscan_byprst_b = 1'b1;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        wvalid = 1'b0;
        bready = 1'b0;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        exp_bresp = '0;
        exp_rresp = '0;
        exp_rdata = '0;
        chk_rdata = 1'b0;
        timeouts = 0;
        model_valid = '0;
        model_on = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        ip_reset_b = 1'b1;
        // Let the IP reset synchronizer release the array
        repeat (3) @(posedge clk);
        #1;

        // Every entry written then read back while powered
        for (int k = 0; k < 4; k++) begin
            rnd = $random(seed);
            store_entry(k[1:0], rnd[7:0], 4'hF);
        end
        for (int k = 0; k < 4; k++)
            load_entry(k[1:0]);
        // Missing byte strobe leaves the entry as it was
        store_entry(2'd1, ~model_mem[1], 4'hE);
        load_entry(2'd1);
        write_word(8'h18, 32'h5A, 4'hF, qed_mem_pkg::SLVERR);
        read_word(8'h24, qed_mem_pkg::SLVERR, 32'h0, 1'b0);
        read_word(8'h02, qed_mem_pkg::SLVERR, 32'h0, 1'b0);

        // Power down, entries refused, then restored and rewritten
        set_power(1'b0);
        store_entry(2'd0, 8'hC3, 4'hF);
        load_entry(2'd2);
        set_power(1'b1);
        load_entry(2'd3);
        store_entry(2'd3, 8'h96, 4'hF);
        load_entry(2'd3);

        // ------------------------------
        // Seeded random operations
        // ------------------------------
        repeat (80) begin
            rnd = $random(seed);
            op  = rnd % 10;
            case (op)
                0, 1, 2: store_entry(rnd[9:8], rnd[23:16], 4'hF);
                3, 4, 5: load_entry(rnd[9:8]);
                6: store_entry(rnd[9:8], rnd[23:16], 4'hE);
                7: begin
                    write_word(8'h18 + {3'b0, rnd[12:10], 2'b00}, 32'h0, 4'hF,
                               qed_mem_pkg::SLVERR);
                    read_word(8'h18 + {3'b0, rnd[15:13], 2'b00}, qed_mem_pkg::SLVERR,
                              32'h0, 1'b0);
                end
                8: read_word(qed_mem_pkg::PWR_CTRL_ADDR, qed_mem_pkg::OKAY,
                             {31'h0, model_on}, 1'b1);
                default: set_power(!model_on);
            endcase
        end

        repeat (2) @(posedge clk);
        $display("Responses checked %0d, check errors %0d, timeouts %0d",
                 checked, errors, timeouts);
        if (errors == 0 && timeouts == 0 && checked > 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- verilog.f
common/qed_mem_pkg.sv
common/rf_access_if.sv
source/mem_reset_sync_scan.sv
rf_pg/rf_array_4x8.sv
rf_pg/qed_mem_rf_pg_4x8.sv
source/pwr_gate_ctrl.sv
source/axil_mem_regs.sv
source/qed_mem_top.sv
dv/qed_mem_checker.sv
dv/tb_qed_mem_top.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and judge the result from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --timescale 1ns/1ps --top-module tb_qed_mem_top \
    -f verilog.f --Mdir obj_dir -o tb_qed_mem_top \
    && ./obj_dir/tb_qed_mem_top > sim.log 2>&1 \
    || { echo "Build or simulation run did not complete"; exit 1; }

cat sim.log
grep -q "Simulation completed successfully" sim.log \
    && { echo "PASS"; exit 0; } \
    || { echo "FAIL"; exit 1; }
